/* logic/zx_spi_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~
// register map of the mcu SPI port
// numbers outside the map decode to REG_NONE
// ~~~~~~~~~~~~~~~~~~~~
package zx_spi_pkg;

	// keyboard matrix geometry
	localparam int KBD_ROWS = 8;
	localparam int KBD_COLS = 5;

	// tape input inside config byte
	localparam int TAPE_BIT = 2;
	// rom page field lsb in reset byte
	localparam int RST_ROM_LSB = 4;

	// read-back for registers without data
	localparam logic [7:0] READ_IDLE = 8'hFF;

	typedef enum logic [3:0] {
		REG_NONE,
		REG_KBD_DATA,
		REG_KBD_COMMIT,
		REG_MUS_X,
		REG_MUS_Y,
		REG_MUS_BTN,
		REG_KJOY,
		REG_RESET,
		REG_WAIT,
		REG_GLUK_ADDR,
		REG_COM_ADDR,
		REG_CONFIG
	} reg_id_e;

	// high nibble picks the group, low bits pick the member
	function automatic reg_id_e decode_reg(input logic [7:0] num);
		reg_id_e id;
		id = REG_NONE;
		case (num[7:4])
			4'h1: id = num[0] ? REG_KBD_COMMIT : REG_KBD_DATA;
			4'h2:
			begin
				case (num[1:0])
					2'd0: id = REG_MUS_X;
					2'd1: id = REG_MUS_Y;
					2'd2: id = REG_MUS_BTN;
					default: id = REG_KJOY;
				endcase
			end
			4'h3: id = REG_RESET;
			4'h4:
			begin
				case (num[1:0])
					2'd0: id = REG_WAIT;
					2'd1: id = REG_GLUK_ADDR;
					2'd2: id = REG_COM_ADDR;
					// 0x43 has no register
					default: id = REG_NONE;
				endcase
			end
			4'h5: id = REG_CONFIG;
			default: id = REG_NONE;
		endcase
		return id;
	endfunction

endpackage

/* logic/spi_reg_link_if.sv */
// ~~~~~~~~~~~~~~~~~~~~
// strobe link from SPI port to register targets
// strobes are one fclk wide, no back-pressure
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface spi_reg_link_if
	import zx_spi_pkg::*;
();
	// decoded register, stable over a data phase
	reg_id_e reg_sel;
	// last complete data byte
	logic [7:0] wdata;
	// eighth bit of a byte taken
	logic byte_stb;
	// chip select fell, data phase begins
	logic start_stb;
	// chip select rose, data phase ends
	logic end_stb;
	// read data, sampled by the port at start_stb
	logic [7:0] rd_data;

	modport port (
		output reg_sel, wdata, byte_stb, start_stb, end_stb,
		input  rd_data
	);

	modport target (
		input  reg_sel, wdata, byte_stb, start_stb, end_stb,
		output rd_data
	);
endinterface

/* logic/avr_spi_port.sv */
// ~~~~~~~~~~~~~~~~~~~~
// SPI slave for the board mcu, LSB first
// SCK half-period must be well above 3 fclk
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module avr_spi_port
	import zx_spi_pkg::*;
(
	input  logic        fclk,
	input  logic        reset,
	input  logic        spics_n,
	input  logic        spick,
	// mosi
	input  logic        spido,
	// miso
	output logic        spidi,
	input  logic [7:0]  status_in,
	spi_reg_link_if.port link
);

	// two sync stages, third stage only for edge detect
	logic [2:0] cs_sync;
	logic [2:0] sck_sync;
	logic [1:0] mosi_sync;

	logic scs_n;
	logic sdo;
	logic cs_rise;
	logic cs_fall;
	logic sck_rise;

	logic [7:0] reg_num;
	logic [7:0] data_sr;
	logic [7:0] shift_out;
	logic [2:0] bit_cnt;
	logic [7:0] wdata_q;
	logic       byte_stb_q;

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			// idle levels, so no false edge after reset
			cs_sync   <= 3'b111;
			sck_sync  <= 3'b000;
			mosi_sync <= 2'b00;
		end
		else
		begin
			cs_sync   <= {cs_sync[1:0], spics_n};
			sck_sync  <= {sck_sync[1:0], spick};
			mosi_sync <= {mosi_sync[0], spido};
		end
	end

	assign scs_n    = cs_sync[1];
	assign sdo      = mosi_sync[1];
	assign cs_rise  = ~cs_sync[2] & cs_sync[1];
	assign cs_fall  = cs_sync[2] & ~cs_sync[1];
	assign sck_rise = ~sck_sync[2] & sck_sync[1];

	// register number shifts only while cs high
	// cleared one cycle after cs rise, so end_stb still sees it
	always_ff @(posedge fclk)
	begin
		if (reset || cs_rise)
			reg_num <= 8'd0;
		else if (scs_n && sck_rise)
			reg_num <= {sdo, reg_num[7:1]};
	end

	// data phase bit counter and byte strobe
	always_ff @(posedge fclk)
	begin
		if (reset || cs_fall)
		begin
			bit_cnt    <= 3'd0;
			byte_stb_q <= 1'b0;
		end
		else
		begin
			byte_stb_q <= !scs_n && sck_rise && (bit_cnt == 3'd7);
			if (!scs_n && sck_rise)
				bit_cnt <= bit_cnt + 3'd1;
		end
	end

	// incoming byte, wdata updates with byte_stb
	always_ff @(posedge fclk)
	begin
		if (!scs_n && sck_rise)
		begin
			data_sr <= {sdo, data_sr[7:1]};
			if (bit_cnt == 3'd7)
				wdata_q <= {sdo, data_sr[7:1]};
		end
	end

	// outgoing shifter
	// status on cs rise, target read data on cs fall
	always_ff @(posedge fclk)
	begin
		if (reset)
			shift_out <= READ_IDLE;
		else if (cs_rise || cs_fall)
			shift_out <= scs_n ? status_in : link.rd_data;
		else if (sck_rise)
			shift_out <= {1'b0, shift_out[7:1]};
	end

	assign spidi = shift_out[0];

	// single decode point for all targets
	assign link.reg_sel   = decode_reg(reg_num);
	assign link.wdata     = wdata_q;
	assign link.byte_stb  = byte_stb_q;
	assign link.start_stb = cs_fall;
	assign link.end_stb   = cs_rise;

endmodule

/* logic/zx_kbd_matrix.sv */
// ~~~~~~~~~~~~~~~~~~~~
// 8x5 keyboard matrix, active low
// commit transfer must come before the row bytes
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module zx_kbd_matrix
	import zx_spi_pkg::*;
(
	input  logic                fclk,
	input  logic                reset,
	// only the port-side signals are read here
	spi_reg_link_if.target      link,
	input  logic [7:0]          zx_addr_hi,
	output logic [KBD_COLS-1:0] kbd_cols
);

	// rows filled by the mcu
	logic [KBD_ROWS-1:0][KBD_COLS-1:0] shadow_rows;
	// rows seen by the z80
	logic [KBD_ROWS-1:0][KBD_COLS-1:0] live_rows;
	logic [$clog2(KBD_ROWS)-1:0]       row_cnt;

	logic row_wr;
	logic row_rst;
	logic do_commit;

	assign row_wr    = link.byte_stb && (link.reg_sel == REG_KBD_DATA);
	// counter rewinds when the commit phase opens
	assign row_rst   = link.start_stb && (link.reg_sel == REG_KBD_COMMIT);
	assign do_commit = link.end_stb && (link.reg_sel == REG_KBD_COMMIT);

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			// all keys released
			shadow_rows <= '1;
			live_rows   <= '1;
			row_cnt     <= '0;
		end
		else
		begin
			if (row_rst)
				row_cnt <= '0;
			else if (row_wr)
			begin
				shadow_rows[row_cnt] <= link.wdata[KBD_COLS-1:0];
				row_cnt <= row_cnt + 1'b1;
			end
			if (do_commit)
				live_rows <= shadow_rows;
		end
	end

	// low address bit selects a row, selected rows AND together
	always_comb
	begin
		kbd_cols = '1;
		for (int r = 0; r < KBD_ROWS; r++)
		begin
			if (!zx_addr_hi[r])
				kbd_cols = kbd_cols & live_rows[r];
		end
	end

endmodule

/* logic/zx_ctrl_regs.sv */
// ~~~~~~~~~~~~~~~~~~~~
// control registers, latched at end of data phase
// output strobes are one fclk, combinational
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module zx_ctrl_regs
	import zx_spi_pkg::*;
(
	input  logic           fclk,
	input  logic           reset,
	spi_reg_link_if.target link,
	input  logic [7:0]     wait_write,
	input  logic [7:0]     gluclock_addr,
	input  logic [2:0]     comport_addr,
	output logic [7:0]     mus_x,
	output logic [7:0]     mus_y,
	output logic [7:0]     mus_btn,
	output logic [7:0]     kjoy,
	output logic           mus_xstb,
	output logic           mus_ystb,
	output logic           mus_btnstb,
	output logic           kj_stb,
	output logic           genrst,
	output logic [1:0]     rstrom,
	output logic [7:0]     wait_read,
	output logic           wait_end,
	output logic [7:0]     config0,
	output logic           cfg_stb,
	output logic           tape_in_bit
);

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			mus_x     <= 8'd0;
			mus_y     <= 8'd0;
			mus_btn   <= 8'd0;
			kjoy      <= 8'd0;
			rstrom    <= 2'd0;
			wait_read <= 8'd0;
			config0   <= 8'd0;
		end
		else if (link.end_stb)
		begin
			case (link.reg_sel)
				REG_MUS_X:   mus_x     <= link.wdata;
				REG_MUS_Y:   mus_y     <= link.wdata;
				REG_MUS_BTN: mus_btn   <= link.wdata;
				REG_KJOY:    kjoy      <= link.wdata;
				// only the rom page is kept
				REG_RESET:   rstrom    <= link.wdata[RST_ROM_LSB +: 2];
				REG_WAIT:    wait_read <= link.wdata;
				REG_CONFIG:  config0   <= link.wdata;
				default:     ;
			endcase
		end
	end

	// strobes follow the commit edge
	assign mus_xstb   = link.end_stb && (link.reg_sel == REG_MUS_X);
	assign mus_ystb   = link.end_stb && (link.reg_sel == REG_MUS_Y);
	assign mus_btnstb = link.end_stb && (link.reg_sel == REG_MUS_BTN);
	assign kj_stb     = link.end_stb && (link.reg_sel == REG_KJOY);
	// z80 reset pulse
	assign genrst     = link.end_stb && (link.reg_sel == REG_RESET);
	assign wait_end   = link.end_stb && (link.reg_sel == REG_WAIT);
	assign cfg_stb    = link.end_stb && (link.reg_sel == REG_CONFIG);

	assign tape_in_bit = config0[TAPE_BIT];

	// read-back mux
	always_comb
	begin
		case (link.reg_sel)
			REG_WAIT:      link.rd_data = wait_write;
			REG_GLUK_ADDR: link.rd_data = gluclock_addr;
			// serial port address zero-extended
			REG_COM_ADDR:  link.rd_data = {5'd0, comport_addr};
			default:       link.rd_data = READ_IDLE;
		endcase
	end

endmodule

/* logic/zx_spi_top.sv */
// ~~~~~~~~~~~~~~~~~~~~
// mcu register port of the spectrum core
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module zx_spi_top
	import zx_spi_pkg::*;
(
	input  logic                fclk,
	input  logic                reset,
	// mcu SPI pins
	input  logic                spics_n,
	input  logic                spick,
	input  logic                spido,
	output logic                spidi,
	input  logic [7:0]          status_in,
	// z80 keyboard side
	input  logic [7:0]          zx_addr_hi,
	output logic [KBD_COLS-1:0] kbd_cols,
	// core side
	input  logic [7:0]          wait_write,
	input  logic [7:0]          gluclock_addr,
	input  logic [2:0]          comport_addr,
	output logic [7:0]          mus_x,
	output logic [7:0]          mus_y,
	output logic [7:0]          mus_btn,
	output logic [7:0]          kjoy,
	output logic                mus_xstb,
	output logic                mus_ystb,
	output logic                mus_btnstb,
	output logic                kj_stb,
	output logic                genrst,
	output logic [1:0]          rstrom,
	output logic [7:0]          wait_read,
	output logic                wait_end,
	output logic [7:0]          config0,
	output logic                cfg_stb,
	output logic                tape_in_bit
);

	spi_reg_link_if link ();

	avr_spi_port u_port (
		.fclk      (fclk),
		.reset     (reset),
		.spics_n   (spics_n),
		.spick     (spick),
		.spido     (spido),
		.spidi     (spidi),
		.status_in (status_in),
		.link      (link.port)
	);

	// keyboard only listens on the link
	zx_kbd_matrix u_kbd (
		.fclk       (fclk),
		.reset      (reset),
		.link       (link.target),
		.zx_addr_hi (zx_addr_hi),
		.kbd_cols   (kbd_cols)
	);

	zx_ctrl_regs u_regs (
		.fclk          (fclk),
		.reset         (reset),
		.link          (link.target),
		.wait_write    (wait_write),
		.gluclock_addr (gluclock_addr),
		.comport_addr  (comport_addr),
		.mus_x         (mus_x),
		.mus_y         (mus_y),
		.mus_btn       (mus_btn),
		.kjoy          (kjoy),
		.mus_xstb      (mus_xstb),
		.mus_ystb      (mus_ystb),
		.mus_btnstb    (mus_btnstb),
		.kj_stb        (kj_stb),
		.genrst        (genrst),
		.rstrom        (rstrom),
		.wait_read     (wait_read),
		.wait_end      (wait_end),
		.config0       (config0),
		.cfg_stb       (cfg_stb),
		.tape_in_bit   (tape_in_bit)
	);

endmodule

/* verif/tb_clock.sv */
// ~~~~~~~~~~~~~~~~~~~~
// 8 ns fclk, reset high for the first 2 rising edges
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_clock (
	output logic fclk,
	output logic reset
);

	initial
	begin
		fclk = 1'b0;
		forever #4 fclk = ~fclk;
	end

	// release just after the second edge, like the other drivers
	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge fclk);
		#1 reset = 1'b0;
	end

endmodule

/* verif/zx_spi_props.sv */
// ~~~~~~~~~~~~~~~~~~~~
// strobe checks on the control registers
// bound into zx_ctrl_regs from the testbench
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module zx_spi_props (
	input logic fclk,
	input logic reset,
	input logic cfg_stb,
	input logic mus_xstb,
	input logic mus_ystb,
	input logic mus_btnstb,
	input logic kj_stb,
	input logic genrst,
	input logic wait_end
);

	logic [6:0] stb_vec;

	assign stb_vec = {wait_end, genrst, kj_stb, mus_btnstb, mus_ystb, mus_xstb, cfg_stb};

	// every output strobe is a single fclk
	for (genvar i = 0; i < 7; i++)
	begin : g_width
		a_one_cycle: assert property (@(posedge fclk) disable iff (reset)
			stb_vec[i] |=> !stb_vec[i])
			else $error("output strobe %0d held for more than one fclk", i);
	end

	// flops are settled from the second reset cycle on
	a_quiet_reset: assert property (@(posedge fclk) (reset && $past(reset)) |-> (stb_vec == '0))
		else $error("output strobe high during reset");

	// a reset write and a config write never end together
	a_no_overlap: assert property (@(posedge fclk) disable iff (reset) !(genrst && cfg_stb))
		else $error("genrst and cfg_stb high in the same cycle");

endmodule

/* verif/zx_spi_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~
// SPI master model for the mcu register port
// SCK half-period fixed at 6 fclk, LSB first
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module zx_spi_tb
	import zx_spi_pkg::*;
();

	// sck half-period in fclk
	localparam int HALF = 6;
	// transfers in the whole run, worst case bits per transfer
	localparam int N_XFERS = 33;
	localparam int XFER_BITS = 72;
	localparam int WATCHDOG_NS = N_XFERS * XFER_BITS * 12 * 8 + 20000;

	logic fclk;
	logic reset;
	logic spics_n;
	logic spick;
	logic spido;
	logic spidi;
	logic [7:0] status_in;
	logic [7:0] zx_addr_hi;
	logic [KBD_COLS-1:0] kbd_cols;
	logic [7:0] wait_write;
	logic [7:0] gluclock_addr;
	logic [2:0] comport_addr;
	logic [7:0] mus_x;
	logic [7:0] mus_y;
	logic [7:0] mus_btn;
	logic [7:0] kjoy;
	logic mus_xstb;
	logic mus_ystb;
	logic mus_btnstb;
	logic kj_stb;
	logic genrst;
	logic [1:0] rstrom;
	logic [7:0] wait_read;
	logic wait_end;
	logic [7:0] config0;
	logic cfg_stb;
	logic tape_in_bit;

	// register model
	logic [7:0] m_cfg;
	logic [7:0] m_mx;
	logic [7:0] m_my;
	logic [7:0] m_mbtn;
	logic [7:0] m_kjoy;
	logic [7:0] m_wait;
	logic [1:0] m_rom;
	logic [KBD_ROWS-1:0][KBD_COLS-1:0] m_shadow;
	logic [KBD_ROWS-1:0][KBD_COLS-1:0] m_live;
	int m_row;

	// strobe pulses seen and expected, cfg first, wait_end last
	logic [6:0] stb_vec;
	int stb_cnt [7];
	int exp_cnt [7];
	string stb_name [7] = '{"cfg_stb", "mus_xstb", "mus_ystb", "mus_btnstb",
		"kj_stb", "genrst", "wait_end"};

	logic [16:0] lfsr;
	logic [7:0] tx_q [$];
	logic [7:0] exp_status;
	logic status_valid;
	logic compare_busy;
	event compare_ev;
	int errors;
	int checks;
	int tests;
	int failed;
	int test_err0;

	tb_clock u_clk (
		.fclk  (fclk),
		.reset (reset)
	);

	zx_spi_top u_dut (.*);

	bind zx_ctrl_regs zx_spi_props u_props (.*);

	// fibonacci lfsr x^17 + x^14 + 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[16] ^ lfsr[13];
		lfsr = {lfsr[15:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < 8; i++)
			v = {v[6:0], lfsr_bit()};
		return v;
	endfunction

	// expected output value from the model
	// sig 0..7 registers, 8 kbd columns for addr, 9 read-back of register addr
	function automatic logic [7:0] ref_value(input int sig, input logic [7:0] addr);
		logic [KBD_COLS-1:0] cols;
		logic [7:0] v;
		cols = '1;
		case (sig)
			0: v = m_cfg;
			1: v = m_mx;
			2: v = m_my;
			3: v = m_mbtn;
			4: v = m_kjoy;
			5: v = {6'd0, m_rom};
			6: v = m_wait;
			7: v = {7'd0, m_cfg[2]};
			8:
			begin
				// a zero address bit selects that row
				for (int r = 0; r < KBD_ROWS; r++)
					if (!addr[r])
						cols = cols & m_live[r];
				v = {3'd0, cols};
			end
			default:
			begin
				case (addr)
					8'h40: v = wait_write;
					8'h41: v = gluclock_addr;
					8'h42: v = {5'd0, comport_addr};
					default: v = 8'hFF;
				endcase
			end
		endcase
		return v;
	endfunction

	// apply a finished transfer, decode by register number
	task automatic model_xfer(input logic [7:0] num);
		logic [7:0] last;
		last = (tx_q.size() > 0) ? tx_q[$] : 8'h00;
		case (num[7:4])
			4'h1:
			begin
				if (num[0])
				begin
					// commit rewinds the row counter, then copies
					m_row = 0;
					m_live = m_shadow;
				end
				else
				begin
					foreach (tx_q[i])
					begin
						m_shadow[m_row] = tx_q[i][KBD_COLS-1:0];
						m_row = (m_row + 1) % KBD_ROWS;
					end
				end
			end
			4'h2:
			begin
				case (num[1:0])
					2'd0: m_mx = last;
					2'd1: m_my = last;
					2'd2: m_mbtn = last;
					default: m_kjoy = last;
				endcase
				exp_cnt[1 + int'(num[1:0])]++;
			end
			4'h3:
			begin
				m_rom = last[5:4];
				exp_cnt[5]++;
			end
			4'h4:
			begin
				// only 0x40 is writable in this group
				if (num[1:0] == 2'd0)
				begin
					m_wait = last;
					exp_cnt[6]++;
				end
			end
			4'h5:
			begin
				m_cfg = last;
				exp_cnt[0]++;
			end
			default: ;
		endcase
	endtask

	task automatic check_val(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp)
		else
		begin
			errors++;
			$display("Fail %s: got %h expected %h", name, got, exp);
		end
	endtask

	// count pulses away from the active edge
	assign stb_vec = {wait_end, genrst, kj_stb, mus_btnstb, mus_ystb, mus_xstb, cfg_stb};

	always @(negedge fclk)
	begin
		if (!reset)
			for (int i = 0; i < 7; i++)
				if (stb_vec[i])
					stb_cnt[i]++;
	end

	// compares every output with the model
	always @(compare_ev)
	begin
		check_val("config0", config0, ref_value(0, 8'h00));
		check_val("mus_x", mus_x, ref_value(1, 8'h00));
		check_val("mus_y", mus_y, ref_value(2, 8'h00));
		check_val("mus_btn", mus_btn, ref_value(3, 8'h00));
		check_val("kjoy", kjoy, ref_value(4, 8'h00));
		check_val("rstrom", {6'd0, rstrom}, ref_value(5, 8'h00));
		check_val("wait_read", wait_read, ref_value(6, 8'h00));
		check_val("tape_in_bit", {7'd0, tape_in_bit}, ref_value(7, 8'h00));
		check_val("kbd_cols", {3'd0, kbd_cols}, ref_value(8, zx_addr_hi));
		for (int i = 0; i < 7; i++)
			check_val(stb_name[i], 8'(stb_cnt[i]), 8'(exp_cnt[i]));
		compare_busy = 1'b0;
	end

	task automatic run_compare();
		compare_busy = 1'b1;
		-> compare_ev;
		wait (!compare_busy);
	endtask

	// n edges, then 1 ns into the cycle
	task automatic tick(input int n);
		repeat (n) @(posedge fclk);
		#1;
	endtask

	// miso is sampled just before sck rises
	task automatic shift_bit(input logic b, output logic miso);
		spido = b;
		tick(HALF);
		miso = spidi;
		spick = 1'b1;
		tick(HALF);
		spick = 1'b0;
	endtask

	task automatic shift_byte(input logic [7:0] b, output logic [7:0] rx);
		logic m;
		rx = '0;
		for (int i = 0; i < 8; i++)
		begin
			shift_bit(b[i], m);
			rx[i] = m;
		end
	endtask

	// register number with cs high, then tx_q with cs low
	task automatic transfer(input logic [7:0] num);
		logic [7:0] st;
		logic [7:0] rx;
		shift_byte(num, st);
		if (status_valid)
			check_val("spidi status", st, exp_status);
		tick(HALF);
		spics_n = 1'b0;
		foreach (tx_q[i])
		begin
			shift_byte(tx_q[i], rx);
			// read data only in the first byte
			if (i == 0)
				check_val("spidi read", rx, ref_value(9, num));
		end
		tick(HALF);
		// new status, captured by the cs rise
		status_in = rand_byte();
		exp_status = status_in;
		status_valid = 1'b1;
		spics_n = 1'b1;
		tick(HALF);
		model_xfer(num);
	endtask

	task automatic send_write(input logic [7:0] num, input int n);
		tx_q.delete();
		repeat (n)
			tx_q.push_back(rand_byte());
		transfer(num);
		run_compare();
	endtask

	task automatic probe_rows(input int n);
		repeat (n)
		begin
			zx_addr_hi = rand_byte();
			tick(1);
			check_val("kbd_cols", {3'd0, kbd_cols}, ref_value(8, zx_addr_hi));
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_err0)
			$display("test %s: ok", name);
		else
		begin
			failed++;
			$display("test %s: %0d errors", name, errors - test_err0);
		end
		test_err0 = errors;
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

	initial
	begin
		lfsr = 17'd95037;
		spics_n = 1'b1;
		spick = 1'b0;
		spido = 1'b0;
		status_in = 8'h00;
		zx_addr_hi = 8'hFF;
		wait_write = 8'h00;
		gluclock_addr = 8'h00;
		comport_addr = 3'd0;
		// model at reset, matrix released
		m_cfg = 8'h00;
		m_mx = 8'h00;
		m_my = 8'h00;
		m_mbtn = 8'h00;
		m_kjoy = 8'h00;
		m_wait = 8'h00;
		m_rom = 2'd0;
		m_shadow = '1;
		m_live = '1;
		m_row = 0;
		for (int i = 0; i < 7; i++)
		begin
			stb_cnt[i] = 0;
			exp_cnt[i] = 0;
		end
		status_valid = 1'b0;
		compare_busy = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		failed = 0;
		test_err0 = 0;

		@(negedge reset);
		tick(2);
		run_compare();
		end_test("reset");

		repeat (4)
			send_write(8'h50, 1);
		end_test("config");

		for (int n = 0; n < 4; n++)
			repeat (2)
				send_write(8'h20 + 8'(n), 1);
		end_test("mouse_joystick");

		repeat (3)
			send_write(8'h30, 1);
		end_test("reset_register");

		// commit first, rows next, commit again
		repeat (2)
		begin
			send_write(8'h11, 0);
			send_write(8'h10, KBD_ROWS);
			probe_rows(8);
			send_write(8'h11, 0);
			probe_rows(8);
		end
		end_test("keyboard");

		wait_write = rand_byte();
		gluclock_addr = rand_byte();
		// three lfsr bits for the 3-bit serial port address
		for (int i = 0; i < 3; i++)
			comport_addr = {comport_addr[1:0], lfsr_bit()};
		send_write(8'h40, 1);
		send_write(8'h41, 1);
		send_write(8'h42, 1);
		send_write(8'h43, 1);
		send_write(8'h60, 1);
		end_test("read_back");

		repeat (3)
			send_write(8'h40, 1);
		// unused numbers, nothing may move
		send_write(8'h60, 1);
		send_write(8'h43, 1);
		send_write(8'h00, 1);
		send_write(8'hA5, 2);
		end_test("wait_port");

		$display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* src.f */
logic/zx_spi_pkg.sv
logic/spi_reg_link_if.sv
logic/avr_spi_port.sv
logic/zx_kbd_matrix.sv
logic/zx_ctrl_regs.sv
logic/zx_spi_top.sv
verif/tb_clock.sv
verif/zx_spi_props.sv
verif/zx_spi_tb.sv

/* Makefile */
TOP = zx_spi_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f src.f -Mdir obj_dir

run: compile
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q '^STATUS: PASS$$'

clean:
	rm -rf obj_dir
